//--- verilog/xbar_pkg.sv
// Crossbar package with data widths, Wishbone register map and reset values
`default_nettype none

package xbar_pkg;

    // Data path geometry
    localparam int DATA_W    = 16;
    localparam int NUM_PORTS = 4;
    localparam int SEL_W     = 2;

    // Wishbone slave port widths, word addressed
    localparam int WB_DATA_W = 32;
    localparam int WB_ADR_W  = 2;

    // Register map
    // Route register packs one 2-bit source select per output, out0 in the low bits
    localparam logic [WB_ADR_W-1:0] ADR_ROUTE = 2'd0;
    // Addends of out0 (low half) and out1 (high half)
    localparam logic [WB_ADR_W-1:0] ADR_ADD01 = 2'd1;
    // Addends of out2 (low half) and out3 (high half)
    localparam logic [WB_ADR_W-1:0] ADR_ADD23 = 2'd2;

    // Identity route, out n takes in n
    localparam logic [2*NUM_PORTS-1:0] RESET_ROUTE = 8'b11100100;

    // Every output adds one after reset
    localparam logic [DATA_W-1:0] RESET_ADDEND = 16'd1;

endpackage

`default_nettype wire

//--- verilog/cla_adder.sv
// Carry-lookahead adder from 4-bit lookahead groups, modulo the word width
`timescale 1ns/1ps
`default_nettype none

module cla_adder (
    input  wire logic [xbar_pkg::DATA_W-1:0] a,
    input  wire logic [xbar_pkg::DATA_W-1:0] b,
    output logic      [xbar_pkg::DATA_W-1:0] sum
);
    import xbar_pkg::*;

    // Bitwise propagate and generate
    logic [DATA_W-1:0] p;
    logic [DATA_W-1:0] g;

    // Carry into each bit; there is no carry-in and the carry-out is dropped
    logic [DATA_W-1:0] c;

    assign p = a ^ b;
    assign g = a & b;
    assign c[0] = 1'b0;

    for (genvar grp = 0; grp < DATA_W/4; grp++) begin : g_group
        logic [3:0] gp;
        logic [3:0] gg;
        logic       ci;

        assign gp = p[4*grp +: 4];
        assign gg = g[4*grp +: 4];
        assign ci = c[4*grp];

        // Internal carries, all formed in parallel from the group carry-in
        assign c[4*grp+1] = gg[0]
                          | (gp[0] & ci);
        assign c[4*grp+2] = gg[1]
                          | (gp[1] & gg[0])
                          | (gp[1] & gp[0] & ci);
        assign c[4*grp+3] = gg[2]
                          | (gp[2] & gg[1])
                          | (gp[2] & gp[1] & gg[0])
                          | (gp[2] & gp[1] & gp[0] & ci);

        // Group carry into the next group, skipped for the top group
        if (grp < DATA_W/4 - 1) begin : g_carry
            logic blk_p;
            logic blk_g;

            assign blk_p = &gp;
            assign blk_g = gg[3]
                         | (gp[3] & gg[2])
                         | (gp[3] & gp[2] & gg[1])
                         | (gp[3] & gp[2] & gp[1] & gg[0]);

            assign c[4*grp+4] = blk_g | (blk_p & ci);
        end
    end

    assign sum = p ^ c;

endmodule

`default_nettype wire

//--- verilog/xbar_cfg_wb.sv
// Wishbone classic slave holding the crossbar route and per-output addend registers
`timescale 1ns/1ps
`default_nettype none

module xbar_cfg_wb (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           wb_cyc,
    input  wire logic                           wb_stb,
    input  wire logic                           wb_we,
    input  wire logic [xbar_pkg::WB_ADR_W-1:0]  wb_adr,
    input  wire logic [xbar_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic      [xbar_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                                wb_ack,
    output logic      [2*xbar_pkg::NUM_PORTS-1:0] route,
    output logic      [xbar_pkg::DATA_W-1:0]    add0,
    output logic      [xbar_pkg::DATA_W-1:0]    add1,
    output logic      [xbar_pkg::DATA_W-1:0]    add2,
    output logic      [xbar_pkg::DATA_W-1:0]    add3
);
    import xbar_pkg::*;

    logic                 req;
    logic [WB_DATA_W-1:0] rd_data;

    // New request only while no ack is outstanding, so each strobe gets one ack
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Read data for the addressed register
    always_comb begin
        case (wb_adr)
            ADR_ROUTE: rd_data = {{(WB_DATA_W-2*NUM_PORTS){1'b0}}, route};
            ADR_ADD01: rd_data = {add1, add0};
            ADR_ADD23: rd_data = {add3, add2};
            default:   rd_data = '0;
        endcase
    end

    // Single-cycle acknowledge
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Read data is captured with the ack and held while it is high
    always_ff @(posedge clock) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    // Configuration registers, written on the acknowledging edge
    always_ff @(posedge clock) begin
        if (reset) begin
            route <= RESET_ROUTE;
            add0  <= RESET_ADDEND;
            add1  <= RESET_ADDEND;
            add2  <= RESET_ADDEND;
            add3  <= RESET_ADDEND;
        end else if (req && wb_we) begin
            case (wb_adr)
                ADR_ROUTE: begin
                    route <= wb_dat_w[2*NUM_PORTS-1:0];
                end
                ADR_ADD01: begin
                    add0 <= wb_dat_w[DATA_W-1:0];
                    add1 <= wb_dat_w[WB_DATA_W-1:DATA_W];
                end
                ADR_ADD23: begin
                    add2 <= wb_dat_w[DATA_W-1:0];
                    add3 <= wb_dat_w[WB_DATA_W-1:DATA_W];
                end
                // Address 3 has no register behind it
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/xbar_switch.sv
// Crossbar switch with registered inputs and route, then a registered selection stage
`timescale 1ns/1ps
`default_nettype none

module xbar_switch (
    input  wire logic                             clock,
    input  wire logic                             reset,
    input  wire logic [xbar_pkg::DATA_W-1:0]      in0,
    input  wire logic [xbar_pkg::DATA_W-1:0]      in1,
    input  wire logic [xbar_pkg::DATA_W-1:0]      in2,
    input  wire logic [xbar_pkg::DATA_W-1:0]      in3,
    input  wire logic [2*xbar_pkg::NUM_PORTS-1:0] route,
    output logic      [xbar_pkg::DATA_W-1:0]      sw0,
    output logic      [xbar_pkg::DATA_W-1:0]      sw1,
    output logic      [xbar_pkg::DATA_W-1:0]      sw2,
    output logic      [xbar_pkg::DATA_W-1:0]      sw3
);
    import xbar_pkg::*;

    // First stage, inputs and route captured on the same edge
    logic [DATA_W-1:0]      in_q [NUM_PORTS];
    logic [2*NUM_PORTS-1:0] route_q;

    // Selected source word per output
    logic [DATA_W-1:0]      pick [NUM_PORTS];

    always_ff @(posedge clock) begin
        if (reset) begin
            in_q    <= '{default: '0};
            route_q <= '0;
        end else begin
            in_q[0] <= in0;
            in_q[1] <= in1;
            in_q[2] <= in2;
            in_q[3] <= in3;
            route_q <= route;
        end
    end

    // One selector per output, driven by that output's field of the captured route.
    // Since route_q travels with in_q, a route change switches on a word boundary.
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            case (route_q[SEL_W*o +: SEL_W])
                2'd0:    pick[o] = in_q[0];
                2'd1:    pick[o] = in_q[1];
                2'd2:    pick[o] = in_q[2];
                default: pick[o] = in_q[3];
            endcase
        end
    end

    // Second stage
    always_ff @(posedge clock) begin
        if (reset) begin
            sw0 <= '0;
            sw1 <= '0;
            sw2 <= '0;
            sw3 <= '0;
        end else begin
            sw0 <= pick[0];
            sw1 <= pick[1];
            sw2 <= pick[2];
            sw3 <= pick[3];
        end
    end

endmodule

`default_nettype wire

//--- verilog/xbar_offset_stage.sv
// Output stage adding each output's addend to its switch word and registering the sum
`timescale 1ns/1ps
`default_nettype none

module xbar_offset_stage (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic [xbar_pkg::DATA_W-1:0] sw0,
    input  wire logic [xbar_pkg::DATA_W-1:0] sw1,
    input  wire logic [xbar_pkg::DATA_W-1:0] sw2,
    input  wire logic [xbar_pkg::DATA_W-1:0] sw3,
    input  wire logic [xbar_pkg::DATA_W-1:0] add0,
    input  wire logic [xbar_pkg::DATA_W-1:0] add1,
    input  wire logic [xbar_pkg::DATA_W-1:0] add2,
    input  wire logic [xbar_pkg::DATA_W-1:0] add3,
    output logic      [xbar_pkg::DATA_W-1:0] out0,
    output logic      [xbar_pkg::DATA_W-1:0] out1,
    output logic      [xbar_pkg::DATA_W-1:0] out2,
    output logic      [xbar_pkg::DATA_W-1:0] out3
);
    import xbar_pkg::*;

    logic [DATA_W-1:0] sum0;
    logic [DATA_W-1:0] sum1;
    logic [DATA_W-1:0] sum2;
    logic [DATA_W-1:0] sum3;

    // Addends come straight from the config registers, so a write shows on the next edge
    cla_adder u_add0 (.a(sw0), .b(add0), .sum(sum0));
    cla_adder u_add1 (.a(sw1), .b(add1), .sum(sum1));
    cla_adder u_add2 (.a(sw2), .b(add2), .sum(sum2));
    cla_adder u_add3 (.a(sw3), .b(add3), .sum(sum3));

    // Third pipeline stage
    always_ff @(posedge clock) begin
        if (reset) begin
            out0 <= '0;
            out1 <= '0;
            out2 <= '0;
            out3 <= '0;
        end else begin
            out0 <= sum0;
            out1 <= sum1;
            out2 <= sum2;
            out3 <= sum3;
        end
    end

endmodule

`default_nettype wire

//--- verilog/xbar_top.sv
// Four-port pipelined crossbar with per-output offset and Wishbone configuration
`timescale 1ns/1ps
`default_nettype none

module xbar_top (
    input  wire logic                           clock,
    input  wire logic                           reset,
    input  wire logic                           wb_cyc,
    input  wire logic                           wb_stb,
    input  wire logic                           wb_we,
    input  wire logic [xbar_pkg::WB_ADR_W-1:0]  wb_adr,
    input  wire logic [xbar_pkg::WB_DATA_W-1:0] wb_dat_w,
    output logic      [xbar_pkg::WB_DATA_W-1:0] wb_dat_r,
    output logic                                wb_ack,
    input  wire logic [xbar_pkg::DATA_W-1:0]    in0,
    input  wire logic [xbar_pkg::DATA_W-1:0]    in1,
    input  wire logic [xbar_pkg::DATA_W-1:0]    in2,
    input  wire logic [xbar_pkg::DATA_W-1:0]    in3,
    output logic      [xbar_pkg::DATA_W-1:0]    out0,
    output logic      [xbar_pkg::DATA_W-1:0]    out1,
    output logic      [xbar_pkg::DATA_W-1:0]    out2,
    output logic      [xbar_pkg::DATA_W-1:0]    out3
);
    import xbar_pkg::*;

    // Configuration to data path
    logic [2*NUM_PORTS-1:0] route;
    logic [DATA_W-1:0]      add0;
    logic [DATA_W-1:0]      add1;
    logic [DATA_W-1:0]      add2;
    logic [DATA_W-1:0]      add3;

    // Switch to offset stage
    logic [DATA_W-1:0]      sw0;
    logic [DATA_W-1:0]      sw1;
    logic [DATA_W-1:0]      sw2;
    logic [DATA_W-1:0]      sw3;

    xbar_cfg_wb u_cfg (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .route    (route),
        .add0     (add0),
        .add1     (add1),
        .add2     (add2),
        .add3     (add3)
    );

    xbar_switch u_switch (
        .clock (clock),
        .reset (reset),
        .in0   (in0),
        .in1   (in1),
        .in2   (in2),
        .in3   (in3),
        .route (route),
        .sw0   (sw0),
        .sw1   (sw1),
        .sw2   (sw2),
        .sw3   (sw3)
    );

    xbar_offset_stage u_offset (
        .clock (clock),
        .reset (reset),
        .sw0   (sw0),
        .sw1   (sw1),
        .sw2   (sw2),
        .sw3   (sw3),
        .add0  (add0),
        .add1  (add1),
        .add2  (add2),
        .add3  (add3),
        .out0  (out0),
        .out1  (out1),
        .out2  (out2),
        .out3  (out3)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Testbench clock and reset generator with a 40 ns clock and a two-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Released shortly after the edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/xbar_chk.sv
// Wishbone acknowledge and reset assertions bound into the configuration slave
`timescale 1ns/1ps
`default_nettype none

module xbar_chk (
    input wire logic clock,
    input wire logic reset,
    input wire logic wb_cyc,
    input wire logic wb_stb,
    input wire logic wb_ack
);

    // Ack lasts exactly one clock
    ack_single_cycle: assert property (
        @(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack
    ) else $error("wb_ack stayed high for two cycles");

    // Every ack answers a strobe the master held in the previous cycle
    ack_after_request: assert property (
        @(posedge clock) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb)
    ) else $error("wb_ack rose without a pending request");

    ack_low_after_reset: assert property (
        @(posedge clock)
        reset |=> !wb_ack
    ) else $error("wb_ack high in the cycle after reset");

endmodule

bind xbar_cfg_wb xbar_chk u_chk (
    .clock  (clock),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

`default_nettype wire

//--- tb/xbar_tb.sv
// Table-driven testbench for the four-port crossbar with Wishbone configuration
`timescale 1ns/1ps
`default_nettype none

module xbar_tb;
    import xbar_pkg::*;

    // Input sampled on edge k shows on the outputs after edge k+2
    localparam int LATENCY     = 3;
    localparam int NUM_TESTS   = 9;
    localparam int ACK_TIMEOUT = 16;
    localparam int RST_TIMEOUT = 20;
    localparam int DRIVE_DLY   = 2;

    logic                 clock;
    logic                 reset;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADR_W-1:0]  wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_w;
    logic [WB_DATA_W-1:0] wb_dat_r;
    logic                 wb_ack;
    logic [DATA_W-1:0]    in0;
    logic [DATA_W-1:0]    in1;
    logic [DATA_W-1:0]    in2;
    logic [DATA_W-1:0]    in3;
    logic [DATA_W-1:0]    out0;
    logic [DATA_W-1:0]    out1;
    logic [DATA_W-1:0]    out2;
    logic [DATA_W-1:0]    out3;

    // Reference model state
    logic [2*NUM_PORTS-1:0]        model_route;
    logic [DATA_W-1:0]             model_add [NUM_PORTS];
    logic [DATA_W-1:0]             cur_in [NUM_PORTS];
    logic [NUM_PORTS*DATA_W-1:0]   sel_q [$];
    string                         name_q [$];
    string                         test_name;
    logic [31:0]                   rng;
    bit                            rand_mode;
    bit                            timed_out;
    int unsigned                   mismatches;
    int unsigned                   timeouts;

    // Stimulus table
    string                t_name [NUM_TESTS];
    bit                   t_write [NUM_TESTS];
    logic [WB_ADR_W-1:0]  t_adr [NUM_TESTS];
    logic [WB_DATA_W-1:0] t_dat [NUM_TESTS];
    bit                   t_rand [NUM_TESTS];
    logic [DATA_W-1:0]    t_in [NUM_TESTS][NUM_PORTS];
    int                   t_cycles [NUM_TESTS];

    tb_clock_gen u_clk (
        .clock (clock),
        .reset (reset)
    );

    xbar_top u_dut (
        .clock    (clock),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .in0      (in0),
        .in1      (in1),
        .in2      (in2),
        .in3      (in3),
        .out0     (out0),
        .out1     (out1),
        .out2     (out2),
        .out3     (out3)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [DATA_W-1:0] out_word(input int port);
        case (port)
            0:       return out0;
            1:       return out1;
            2:       return out2;
            default: return out3;
        endcase
    endfunction

    // Register contents as the map defines them, built from the model
    function automatic logic [WB_DATA_W-1:0] expected_reg(input logic [WB_ADR_W-1:0] adr);
        logic [WB_DATA_W-1:0] word;
        word = '0;
        if (adr == ADR_ROUTE) begin
            word[2*NUM_PORTS-1:0] = model_route;
        end else if (adr == ADR_ADD01) begin
            word[DATA_W-1:0] = model_add[0];
            word[WB_DATA_W-1:DATA_W] = model_add[1];
        end else if (adr == ADR_ADD23) begin
            word[DATA_W-1:0] = model_add[2];
            word[WB_DATA_W-1:DATA_W] = model_add[3];
        end
        return word;
    endfunction

    task automatic compare_data(input string name, input int port,
                                input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH test %s out%0d expected %h actual %h", name, port, exp, act);
            mismatches++;
        end
    endtask

    task automatic compare_reg(input string name, input logic [WB_ADR_W-1:0] adr,
                               input logic [WB_DATA_W-1:0] exp,
                               input logic [WB_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH test %s reg %0d expected %h actual %h", name, adr, exp, act);
            mismatches++;
        end
    endtask

    task automatic apply_inputs();
        in0 = cur_in[0];
        in1 = cur_in[1];
        in2 = cur_in[2];
        in3 = cur_in[3];
    endtask

    // One clock: record the sampled words, check the words from three edges back
    task automatic advance_cycle();
        logic [NUM_PORTS*DATA_W-1:0] sel;
        logic [NUM_PORTS*DATA_W-1:0] old;
        logic [DATA_W-1:0]           exp_w;
        string                       old_name;
        @(posedge clock);
        #DRIVE_DLY;
        for (int o = 0; o < NUM_PORTS; o++) begin
            sel[o*DATA_W +: DATA_W] = cur_in[model_route[o*SEL_W +: SEL_W]];
        end
        sel_q.push_back(sel);
        name_q.push_back(test_name);
        old = sel_q.pop_front();
        old_name = name_q.pop_front();
        // Addend in force on this edge, before any write acked here
        for (int o = 0; o < NUM_PORTS; o++) begin
            exp_w = old[o*DATA_W +: DATA_W] + model_add[o];
            compare_data(old_name, o, exp_w, out_word(o));
        end
        if (rand_mode) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                rng = xorshift(rng);
                cur_in[o] = rng[DATA_W-1:0];
            end
            apply_inputs();
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                             input logic [WB_DATA_W-1:0] dat, output logic acked);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = dat;
        waited = 0;
        do begin
            advance_cycle();
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        acked = wb_ack;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (!acked) begin
            $display("ERROR: test %s got no Wishbone acknowledge at address %0d",
                     test_name, adr);
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic write_reg(input logic [WB_ADR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat);
        logic acked;
        bus_cycle(1'b1, adr, dat, acked);
        if (acked) begin
            if (adr == ADR_ROUTE) begin
                model_route = dat[2*NUM_PORTS-1:0];
            end else if (adr == ADR_ADD01) begin
                model_add[0] = dat[DATA_W-1:0];
                model_add[1] = dat[WB_DATA_W-1:DATA_W];
            end else if (adr == ADR_ADD23) begin
                model_add[2] = dat[DATA_W-1:0];
                model_add[3] = dat[WB_DATA_W-1:DATA_W];
            end
        end
    endtask

    task automatic read_reg(input logic [WB_ADR_W-1:0] adr);
        logic acked;
        bus_cycle(1'b0, adr, '0, acked);
        if (acked) begin
            compare_reg(test_name, adr, expected_reg(adr), wb_dat_r);
        end
    endtask

    task automatic check_regs();
        for (int a = 0; a < 4 && !timed_out; a++) begin
            read_reg(a[WB_ADR_W-1:0]);
        end
    endtask

    task automatic add_entry(input int idx, input string name, input bit wr,
                             input logic [WB_ADR_W-1:0] adr, input logic [WB_DATA_W-1:0] dat,
                             input bit rnd, input logic [DATA_W-1:0] w0, w1, w2, w3,
                             input int cycles);
        t_name[idx] = name;
        t_write[idx] = wr;
        t_adr[idx] = adr;
        t_dat[idx] = dat;
        t_rand[idx] = rnd;
        t_in[idx][0] = w0;
        t_in[idx][1] = w1;
        t_in[idx][2] = w2;
        t_in[idx][3] = w3;
        t_cycles[idx] = cycles;
    endtask

    task automatic load_table();
        add_entry(0, "reset_stream", 1'b0, ADR_ROUTE, '0, 1'b1, '0, '0, '0, '0, 12);
        add_entry(1, "route_broadcast", 1'b1, ADR_ROUTE, 32'h0000_00aa, 1'b1,
                  '0, '0, '0, '0, 10);
        add_entry(2, "route_reverse", 1'b1, ADR_ROUTE, 32'h0000_001b, 1'b1,
                  '0, '0, '0, '0, 10);
        add_entry(3, "addend_ffff", 1'b1, ADR_ADD01, 32'h0001_ffff, 1'b1,
                  '0, '0, '0, '0, 10);
        // Carries run through all four lookahead groups
        add_entry(4, "addend_ripple", 1'b1, ADR_ADD23, 32'h8001_0001, 1'b0,
                  16'hffff, 16'hffff, 16'h7fff, 16'h8fff, 6);
        add_entry(5, "route_change_stream", 1'b1, ADR_ROUTE, 32'h0000_00e4, 1'b1,
                  '0, '0, '0, '0, 8);
        add_entry(6, "route_mixed", 1'b1, ADR_ROUTE, 32'h0000_004e, 1'b1,
                  '0, '0, '0, '0, 8);
        add_entry(7, "adr3_ignored", 1'b1, 2'd3, 32'hffff_ffff, 1'b1,
                  '0, '0, '0, '0, 8);
        add_entry(8, "addend_restore", 1'b1, ADR_ADD01, 32'h0001_0001, 1'b1,
                  '0, '0, '0, '0, 6);
    endtask

    task automatic run_entry(input int t);
        test_name = t_name[t];
        rand_mode = t_rand[t];
        if (!t_rand[t]) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                cur_in[o] = t_in[t][o];
            end
            apply_inputs();
        end
        if (t_write[t]) begin
            write_reg(t_adr[t], t_dat[t]);
            check_regs();
        end
        for (int c = 0; c < t_cycles[t] && !timed_out; c++) begin
            advance_cycle();
        end
    endtask

    initial begin
        int waited;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            cur_in[o] = '0;
            model_add[o] = RESET_ADDEND;
        end
        apply_inputs();
        model_route = RESET_ROUTE;
        rng = 32'hba46;
        rand_mode = 1'b0;
        timed_out = 1'b0;
        mismatches = 0;
        timeouts = 0;
        test_name = "reset_outputs";
        load_table();

        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (reset && waited < RST_TIMEOUT);

        if (reset) begin
            $display("ERROR: reset was never released");
            timeouts++;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                compare_data(test_name, o, '0, out_word(o));
            end
            // Cleared pipeline registers act like two all-zero samples
            for (int i = 0; i < LATENCY - 1; i++) begin
                sel_q.push_back('0);
                name_q.push_back(test_name);
            end
            advance_cycle();
            test_name = "reset_regs";
            check_regs();
            for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
                run_entry(t);
            end
            for (int i = 0; i < LATENCY && !timed_out; i++) begin
                advance_cycle();
            end
        end

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/xbar_pkg.sv
verilog/cla_adder.sv
verilog/xbar_cfg_wb.sv
verilog/xbar_switch.sv
verilog/xbar_offset_stage.sv
verilog/xbar_top.sv
tb/tb_clock_gen.sv
tb/xbar_chk.sv
tb/xbar_tb.sv

//--- run.sh
#!/bin/sh
# Build the crossbar testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module xbar_tb \
    -Mdir obj_dir \
    -o xbar_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/xbar_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
